//--- common/dec_req_if.sv
// Decoded L1.5 request
`timescale 1ns/1ps

interface dec_req_if (
    input logic clk_i,
    input logic valid_i
);
    l15_pkg::rqtype_t                  rqtype;
    logic                              nc;
    l15_pkg::size_t                    size;
    logic [mem_req_pkg::AddrWidth-1:0] address;
    logic [l15_pkg::DataWidth-1:0]     data;   // Already in L1.5 byte order
    logic [l15_pkg::BeWidth-1:0]       be;

    modport driver (
        input  clk_i, valid_i,
        output rqtype, nc, size, address, data, be
    );

    modport consumer (
        input rqtype, nc, size, address, data, be
    );
endinterface

//--- common/l15_pkg.sv
// L1.5 bus definitions
package l15_pkg;

    localparam int TidWidth  = 2;
    localparam int NumTids   = 4;
    localparam int DataWidth = 64;
    localparam int BeWidth   = DataWidth / 8;
    localparam int OffsWidth = $clog2(BeWidth);
    localparam int RespWidth = 128;

    typedef logic [TidWidth-1:0]  tid_t;
    typedef logic [4:0]           rqtype_t;
    typedef logic [2:0]           size_t;
    typedef logic [3:0]           rettype_t;
    typedef logic [OffsWidth-1:0] offs_t;    // Byte offset inside one data word

    localparam rqtype_t RqLoad  = 5'd0;
    localparam rqtype_t RqStore = 5'd1;
    localparam rqtype_t RqImiss = 5'd16;

    localparam size_t Size0B  = 3'd0;
    localparam size_t Size1B  = 3'd1;
    localparam size_t Size2B  = 3'd2;
    localparam size_t Size4B  = 3'd3;
    localparam size_t Size8B  = 3'd4;
    localparam size_t Size16B = 3'd5;
    localparam size_t Size32B = 3'd6;
    localparam size_t Size64B = 3'd7;

    localparam rettype_t RetLoad     = 4'd0;
    localparam rettype_t RetIfill    = 4'd1;
    localparam rettype_t RetEvict    = 4'd3;
    localparam rettype_t RetStoreAck = 4'd4;
    localparam rettype_t RetErr      = 4'd12;

    localparam size_t IcacheCachedSize   = Size32B;  // Full icache line
    localparam size_t IcacheUncachedSize = Size4B;

    // L1.5 words are big-endian
    function automatic logic [DataWidth-1:0] swap_bytes(input logic [DataWidth-1:0] word);
        logic [DataWidth-1:0] res;
        for (int i = 0; i < BeWidth; i++) begin
            res[i*8 +: 8] = word[(BeWidth-1-i)*8 +: 8];
        end
        return res;
    endfunction

endpackage

//--- common/mem_req_pkg.sv
// Cache memory request definitions
package mem_req_pkg;

    localparam int AddrWidth = 40;
    localparam int NumSrc    = 5;

    typedef logic [3:0] mem_id_t;
    typedef logic [2:0] pid_t;
    typedef logic [1:0] cmd_t;

    // Bit positions in the one-hot source index
    localparam int SrcIfill    = 0;
    localparam int SrcRead     = 1;
    localparam int SrcWrite    = 2;
    localparam int SrcUncRead  = 3;
    localparam int SrcUncWrite = 4;

    localparam cmd_t CmdRead  = 2'd0;
    localparam cmd_t CmdWrite = 2'd1;

    localparam pid_t IcachePid = 3'd0;  // Port of icache invalidations

endpackage

//--- common/thid_if.sv
// Thread id allocation and release
`timescale 1ns/1ps

interface thid_if;
    logic                 alloc;        // Request accepted by the L1.5
    l15_pkg::tid_t        alloc_tid;
    mem_req_pkg::mem_id_t alloc_id;
    mem_req_pkg::pid_t    alloc_pid;
    logic                 release_en;   // Response accepted, id back to the free list
    l15_pkg::tid_t        release_tid;

    modport alloc_side (
        output alloc, alloc_tid, alloc_id, alloc_pid,
        input  release_en, release_tid
    );

    modport table_side (
        input  alloc, alloc_tid, alloc_id, alloc_pid,
        output release_en, release_tid
    );
endinterface

//--- rtl/l15_adapter.sv
// Cache to L1.5 adapter
`timescale 1ns/1ps

module l15_adapter (
    input  logic                              clk_i,
    input  logic                              rst_ni,

    input  logic                              req_valid_i,
    output logic                              req_ready_o,
    input  logic [mem_req_pkg::NumSrc-1:0]    req_index_i,
    input  mem_req_pkg::cmd_t                 req_cmd_i,
    input  mem_req_pkg::mem_id_t              req_id_i,
    input  mem_req_pkg::pid_t                 req_pid_i,
    input  logic [mem_req_pkg::AddrWidth-1:0] req_addr_i,
    input  l15_pkg::size_t                    req_size_i,   // log2 of bytes
    input  logic                              req_cacheable_i,
    input  logic [l15_pkg::DataWidth-1:0]     req_wdata_i,
    input  logic [l15_pkg::BeWidth-1:0]       req_wbe_i,

    output logic                              l15_val_o,
    output l15_pkg::rqtype_t                  l15_rqtype_o,
    output logic                              l15_nc_o,
    output l15_pkg::size_t                    l15_size_o,
    output l15_pkg::tid_t                     l15_tid_o,
    output logic [mem_req_pkg::AddrWidth-1:0] l15_address_o,
    output logic [l15_pkg::DataWidth-1:0]     l15_data_o,
    output logic [l15_pkg::BeWidth-1:0]       l15_be_o,
    output logic                              l15_req_ack_o,
    input  logic                              l15_header_ack_i,
    input  logic                              l15_ack_i,

    input  logic                              l15_rtrn_val_i,
    input  l15_pkg::rettype_t                 l15_rtrn_type_i,
    input  l15_pkg::tid_t                     l15_rtrn_tid_i,
    input  logic [l15_pkg::RespWidth-1:0]     l15_rtrn_data_i,
    input  logic                              l15_inval_icache_i,
    input  logic                              l15_inval_dcache_i,
    input  logic [mem_req_pkg::AddrWidth-1:0] l15_inval_addr_i,

    input  logic                              inval_ready_i,
    input  logic                              resp_ready_i,
    output logic                              resp_valid_o,
    output mem_req_pkg::mem_id_t              resp_id_o,
    output mem_req_pkg::pid_t                 resp_pid_o,
    output logic                              resp_error_o,
    output logic [l15_pkg::RespWidth-1:0]     resp_data_o,
    output logic                              inval_icache_o,
    output logic                              inval_dcache_o,
    output logic [mem_req_pkg::AddrWidth-1:0] inval_addr_o
);

    dec_req_if dec (
        .clk_i   (clk_i),
        .valid_i (req_valid_i)
    );
    thid_if thid ();

    req_decode u_decode (
        .req_index_i, .req_cmd_i, .req_addr_i, .req_size_i,
        .req_cacheable_i, .req_wdata_i, .req_wbe_i,
        .dec (dec.driver)
    );

    thread_ctrl u_thread_ctrl (
        .clk_i, .rst_ni, .req_valid_i, .req_id_i, .req_pid_i,
        .l15_header_ack_i, .l15_ack_i,
        .dec  (dec.consumer),
        .thid (thid.alloc_side),
        .req_ready_o, .l15_val_o, .l15_rqtype_o, .l15_nc_o, .l15_size_o,
        .l15_tid_o, .l15_address_o, .l15_data_o, .l15_be_o
    );

    resp_route u_resp_route (
        .clk_i, .rst_ni, .l15_rtrn_val_i, .l15_rtrn_type_i, .l15_rtrn_tid_i,
        .l15_rtrn_data_i, .l15_inval_icache_i, .l15_inval_dcache_i,
        .l15_inval_addr_i, .inval_ready_i, .resp_ready_i,
        .thid (thid.table_side),
        .l15_req_ack_o, .resp_valid_o, .resp_id_o, .resp_pid_o, .resp_error_o,
        .resp_data_o, .inval_icache_o, .inval_dcache_o, .inval_addr_o
    );

endmodule

//--- rtl/req_decode.sv
// Request classification and L1.5 fields
`timescale 1ns/1ps

module req_decode (
    input  logic [mem_req_pkg::NumSrc-1:0]    req_index_i,
    input  mem_req_pkg::cmd_t                 req_cmd_i,
    input  logic [mem_req_pkg::AddrWidth-1:0] req_addr_i,
    input  l15_pkg::size_t                    req_size_i,
    input  logic                              req_cacheable_i,
    input  logic [l15_pkg::DataWidth-1:0]     req_wdata_i,
    input  logic [l15_pkg::BeWidth-1:0]       req_wbe_i,
    dec_req_if.driver                         dec
);

    logic           is_ifill;
    logic           is_read;
    logic           is_write;      // Cached store, the only byte-masked one
    logic           is_unc_read;
    logic           is_unc_write;
    l15_pkg::offs_t first_byte;
    l15_pkg::size_t store_size;

    assign is_ifill     = req_index_i[mem_req_pkg::SrcIfill];
    assign is_read      = req_index_i[mem_req_pkg::SrcRead] & (req_cmd_i == mem_req_pkg::CmdRead);
    assign is_write     = req_index_i[mem_req_pkg::SrcWrite] & (req_cmd_i == mem_req_pkg::CmdWrite);
    assign is_unc_read  = req_index_i[mem_req_pkg::SrcUncRead]
                        & (req_cmd_i == mem_req_pkg::CmdRead);
    assign is_unc_write = req_index_i[mem_req_pkg::SrcUncWrite]
                        & (req_cmd_i == mem_req_pkg::CmdWrite);

    // Lowest enabled byte wins
    always_comb begin
        first_byte = '0;
        for (int i = l15_pkg::BeWidth - 1; i >= 0; i--) begin
            if (req_wbe_i[i]) begin
                first_byte = l15_pkg::offs_t'(i);
            end
        end
    end

    always_comb begin
        case ($countones(req_wbe_i))
            0:       store_size = l15_pkg::Size0B;
            1:       store_size = l15_pkg::Size1B;
            2:       store_size = l15_pkg::Size2B;
            4:       store_size = l15_pkg::Size4B;
            default: store_size = l15_pkg::Size8B;   // Full word
        endcase
    end

    always_comb begin
        if (is_ifill) begin
            dec.size = req_cacheable_i ? l15_pkg::IcacheCachedSize : l15_pkg::IcacheUncachedSize;
        end else if (is_write) begin
            dec.size = store_size;
        end else begin
            dec.size = req_size_i + 3'd1;   // log2 bytes to L1.5 code
        end
    end

    assign dec.rqtype  = is_ifill                    ? l15_pkg::RqImiss :
                         (is_write || is_unc_write)  ? l15_pkg::RqStore : l15_pkg::RqLoad;
    assign dec.nc      = ~req_cacheable_i;
    assign dec.address = is_write
                       ? {req_addr_i[mem_req_pkg::AddrWidth-1:l15_pkg::OffsWidth], first_byte}
                       : req_addr_i;
    assign dec.data    = l15_pkg::swap_bytes(req_wdata_i);

    always_comb begin
        for (int i = 0; i < l15_pkg::BeWidth; i++) begin
            dec.be[l15_pkg::BeWidth-1-i] = req_wbe_i[i];
        end
    end

    // Valid request comes from exactly one known source
    a_one_src: assert property (@(posedge dec.clk_i)
        dec.valid_i |-> $onehot0(req_index_i)
            && (is_ifill || is_read || is_write || is_unc_read || is_unc_write));

endmodule

//--- rtl/resp_route.sv
// L1.5 return routing
`timescale 1ns/1ps

module resp_route (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              l15_rtrn_val_i,
    input  l15_pkg::rettype_t                 l15_rtrn_type_i,
    input  l15_pkg::tid_t                     l15_rtrn_tid_i,
    input  logic [l15_pkg::RespWidth-1:0]     l15_rtrn_data_i,
    input  logic                              l15_inval_icache_i,
    input  logic                              l15_inval_dcache_i,
    input  logic [mem_req_pkg::AddrWidth-1:0] l15_inval_addr_i,
    input  logic                              inval_ready_i,
    input  logic                              resp_ready_i,
    thid_if.table_side                        thid,
    output logic                              l15_req_ack_o,
    output logic                              resp_valid_o,
    output mem_req_pkg::mem_id_t              resp_id_o,
    output mem_req_pkg::pid_t                 resp_pid_o,
    output logic                              resp_error_o,
    output logic [l15_pkg::RespWidth-1:0]     resp_data_o,
    output logic                              inval_icache_o,
    output logic                              inval_dcache_o,
    output logic [mem_req_pkg::AddrWidth-1:0] inval_addr_o
);

    mem_req_pkg::mem_id_t id_tab_q  [l15_pkg::NumTids];
    mem_req_pkg::pid_t    pid_tab_q [l15_pkg::NumTids];
    logic                 only_inval;   // Eviction return, no response inside

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < l15_pkg::NumTids; i++) begin
                id_tab_q[i]  <= '0;
                pid_tab_q[i] <= '0;
            end
        end else if (thid.alloc) begin
            id_tab_q[thid.alloc_tid]  <= thid.alloc_id;
            pid_tab_q[thid.alloc_tid] <= thid.alloc_pid;
        end
    end

    assign only_inval     = (l15_rtrn_type_i == l15_pkg::RetEvict);
    assign inval_icache_o = l15_rtrn_val_i & l15_inval_icache_i;
    assign inval_dcache_o = l15_rtrn_val_i & l15_inval_dcache_i;
    assign inval_addr_o   = l15_inval_addr_i;

    assign resp_valid_o = l15_rtrn_val_i & ~(only_inval & inval_dcache_o);
    assign resp_id_o    = id_tab_q[l15_rtrn_tid_i];
    assign resp_pid_o   = (only_inval & inval_icache_o) ? mem_req_pkg::IcachePid
                                                        : pid_tab_q[l15_rtrn_tid_i];
    assign resp_error_o = (l15_rtrn_type_i == l15_pkg::RetErr);

    // Each returned word back to little-endian
    always_comb begin
        for (int h = 0; h < l15_pkg::RespWidth / l15_pkg::DataWidth; h++) begin
            resp_data_o[h*l15_pkg::DataWidth +: l15_pkg::DataWidth] =
                l15_pkg::swap_bytes(l15_rtrn_data_i[h*l15_pkg::DataWidth +: l15_pkg::DataWidth]);
        end
    end

    always_comb begin
        if (inval_dcache_o && only_inval) begin
            l15_req_ack_o = l15_rtrn_val_i & inval_ready_i;
        end else if (inval_dcache_o) begin
            l15_req_ack_o = l15_rtrn_val_i & inval_ready_i & resp_ready_i;
        end else begin
            l15_req_ack_o = l15_rtrn_val_i & resp_ready_i;
        end
    end

    assign thid.release_en  = l15_req_ack_o & ~only_inval;
    assign thid.release_tid = l15_rtrn_tid_i;

endmodule

//--- run_verilator.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_l15_adapter -f vlog.f -o sim_l15_adapter

out=$(./obj_dir/sim_l15_adapter)
echo "$out"
echo "$out" | grep -q "PASS: all tests"

//--- sim/tb_l15_adapter.sv
// Cache to L1.5 adapter testbench
`timescale 1ns/1ps

module tb_l15_adapter;

    localparam int NumRows = 17;
    localparam int OpReq   = 0;
    localparam int OpBlock = 1;   // Request that must find no free id
    localparam int OpRtrn  = 2;

    typedef struct {
        int                   op;
        logic [4:0]           index;
        mem_req_pkg::cmd_t    cmd;
        l15_pkg::size_t       size;
        logic                 cacheable;
        logic [7:0]           wbe;
        int                   hdr_dly;
        int                   ack_dly;    // Cycles from header_ack to ack
        l15_pkg::rqtype_t     exp_rqtype;
        l15_pkg::size_t       exp_size;
        l15_pkg::tid_t        tid;        // Expected id of a request or returning id
        l15_pkg::rettype_t    rtype;
        logic                 inval_dc;
        logic                 inval_ic;
        logic                 rdy;
        logic                 ivrdy;
        logic                 exp_valid;
        logic                 exp_ack;
    } row_t;

    logic                              clk_i, rst_ni;
    logic                              req_valid_i, req_ready_o, req_cacheable_i;
    logic [mem_req_pkg::NumSrc-1:0]    req_index_i;
    mem_req_pkg::cmd_t                 req_cmd_i;
    mem_req_pkg::mem_id_t              req_id_i, resp_id_o;
    mem_req_pkg::pid_t                 req_pid_i, resp_pid_o;
    logic [mem_req_pkg::AddrWidth-1:0] req_addr_i, l15_address_o, l15_inval_addr_i, inval_addr_o;
    l15_pkg::size_t                    req_size_i, l15_size_o;
    logic [63:0]                       req_wdata_i, l15_data_o;
    logic [7:0]                        req_wbe_i, l15_be_o;
    logic                              l15_val_o, l15_nc_o, l15_req_ack_o;
    l15_pkg::rqtype_t                  l15_rqtype_o;
    l15_pkg::tid_t                     l15_tid_o, l15_rtrn_tid_i;
    logic                              l15_header_ack_i, l15_ack_i, l15_rtrn_val_i;
    l15_pkg::rettype_t                 l15_rtrn_type_i;
    logic [127:0]                      l15_rtrn_data_i, resp_data_o;
    logic                              l15_inval_icache_i, l15_inval_dcache_i;
    logic                              inval_ready_i, resp_ready_i;
    logic                              resp_valid_o, resp_error_o;
    logic                              inval_icache_o, inval_dcache_o;

    row_t                 rows [NumRows];
    string                row_name [NumRows];
    mem_req_pkg::mem_id_t sent_id [4];    // Request id per thread id in flight
    mem_req_pkg::pid_t    sent_pid [4];
    int                   nrows;
    int                   errors;
    int                   failed;
    integer               seed;

    l15_adapter dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        repeat (NumRows * 50) @(posedge clk_i);
        $display("Watchdog expired before all tests had finished");
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
        assert (got === exp) else begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [2:0] first_enabled_byte(input logic [7:0] be);
        int i;
        i = 0;
        while (i < 7 && !be[i]) i++;
        return 3'(i);
    endfunction

    task automatic add_request(input logic [4:0] index, input mem_req_pkg::cmd_t cmd,
                               input l15_pkg::size_t size, input logic cacheable,
                               input logic [7:0] wbe, input int hdr_dly, input int ack_dly,
                               input l15_pkg::rqtype_t exp_rqtype, input l15_pkg::size_t exp_size,
                               input l15_pkg::tid_t exp_tid, input string name);
        rows[nrows].op         = OpReq;
        rows[nrows].index      = index;
        rows[nrows].cmd        = cmd;
        rows[nrows].size       = size;
        rows[nrows].cacheable  = cacheable;
        rows[nrows].wbe        = wbe;
        rows[nrows].hdr_dly    = hdr_dly;
        rows[nrows].ack_dly    = ack_dly;
        rows[nrows].exp_rqtype = exp_rqtype;
        rows[nrows].exp_size   = exp_size;
        rows[nrows].tid        = exp_tid;
        row_name[nrows]        = name;
        nrows++;
    endtask

    task automatic add_blocked(input string name);
        rows[nrows].op        = OpBlock;
        rows[nrows].index     = 5'h02;    // Cached load
        rows[nrows].cmd       = mem_req_pkg::CmdRead;
        rows[nrows].cacheable = 1'b1;
        row_name[nrows]       = name;
        nrows++;
    endtask

    task automatic add_return(input l15_pkg::tid_t tid, input l15_pkg::rettype_t rtype,
                              input logic inval_dc, input logic inval_ic,
                              input logic rdy, input logic ivrdy,
                              input logic exp_valid, input logic exp_ack, input string name);
        rows[nrows].op        = OpRtrn;
        rows[nrows].tid       = tid;
        rows[nrows].rtype     = rtype;
        rows[nrows].inval_dc  = inval_dc;
        rows[nrows].inval_ic  = inval_ic;
        rows[nrows].rdy       = rdy;
        rows[nrows].ivrdy     = ivrdy;
        rows[nrows].exp_valid = exp_valid;
        rows[nrows].exp_ack   = exp_ack;
        row_name[nrows]       = name;
        nrows++;
    endtask

    task automatic run_request(input int r);
        logic [mem_req_pkg::AddrWidth-1:0] addr;
        logic [mem_req_pkg::AddrWidth-1:0] exp_addr;
        logic [63:0]                       wdata;
        logic [63:0]                       exp_data;
        logic [7:0]                        wbe;
        logic [7:0]                        exp_be;
        int                                done_at;
        addr     = {8'($random(seed)), $random(seed)};
        wdata    = {$random(seed), $random(seed)};
        wbe      = rows[r].wbe;
        exp_addr = addr;
        if (rows[r].index[mem_req_pkg::SrcWrite]) begin
            exp_addr[2:0] = first_enabled_byte(wbe);   // Cached store aligned to first byte
        end
        exp_data = {<<8{wdata}};
        exp_be   = {<<{wbe}};
        done_at  = rows[r].hdr_dly + rows[r].ack_dly;
        @(posedge clk_i);
        req_valid_i      <= 1'b1;
        req_index_i      <= rows[r].index;
        req_cmd_i        <= rows[r].cmd;
        req_id_i         <= 4'(r);
        req_pid_i        <= 3'(r);
        req_addr_i       <= addr;
        req_size_i       <= rows[r].size;
        req_cacheable_i  <= rows[r].cacheable;
        req_wdata_i      <= wdata;
        req_wbe_i        <= wbe;
        l15_header_ack_i <= (rows[r].hdr_dly == 0);
        l15_ack_i        <= (done_at == 0);
        for (int cyc = 0; cyc <= done_at; cyc++) begin
            if (cyc > 0) begin
                @(posedge clk_i);
                l15_header_ack_i <= (cyc == rows[r].hdr_dly);
                l15_ack_i        <= (cyc == done_at);
            end
            @(negedge clk_i);
            if (cyc == 0) begin
                check_eq("l15_rqtype_o", l15_rqtype_o, rows[r].exp_rqtype);
                check_eq("l15_size_o", l15_size_o, rows[r].exp_size);
                check_eq("l15_nc_o", l15_nc_o, !rows[r].cacheable);
                check_eq("l15_tid_o", l15_tid_o, rows[r].tid);
                check_eq("l15_address_o", l15_address_o, exp_addr);
                check_eq("l15_data_o", l15_data_o, exp_data);
                check_eq("l15_be_o", l15_be_o, exp_be);
            end
            check_eq("l15_val_o", l15_val_o, cyc <= rows[r].hdr_dly);   // Low in WAIT_ACK
            check_eq("req_ready_o", req_ready_o, cyc == done_at);
        end
        if (req_ready_o) begin
            sent_id[rows[r].tid]  = 4'(r);
            sent_pid[rows[r].tid] = 3'(r);
        end
        @(posedge clk_i);
        req_valid_i      <= 1'b0;
        l15_header_ack_i <= 1'b0;
        l15_ack_i        <= 1'b0;
    endtask

    task automatic run_blocked(input int r);
        @(posedge clk_i);
        req_valid_i     <= 1'b1;
        req_index_i     <= rows[r].index;
        req_cmd_i       <= rows[r].cmd;
        req_cacheable_i <= rows[r].cacheable;
        repeat (4) begin
            @(negedge clk_i);
            check_eq("l15_val_o", l15_val_o, 1'b0);
            check_eq("req_ready_o", req_ready_o, 1'b0);
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    task automatic run_return(input int r);
        logic [127:0]                      rdata;
        logic [63:0]                       exp_lo;
        logic [63:0]                       exp_hi;
        logic [mem_req_pkg::AddrWidth-1:0] iaddr;
        mem_req_pkg::pid_t                 exp_pid;
        rdata   = {$random(seed), $random(seed), $random(seed), $random(seed)};
        iaddr   = {8'($random(seed)), $random(seed)};
        exp_lo  = {<<8{rdata[63:0]}};
        exp_hi  = {<<8{rdata[127:64]}};
        exp_pid = sent_pid[rows[r].tid];
        if (rows[r].inval_ic && rows[r].rtype == l15_pkg::RetEvict) begin
            exp_pid = mem_req_pkg::IcachePid;   // Icache invalidations have their own port
        end
        @(posedge clk_i);
        l15_rtrn_val_i     <= 1'b1;
        l15_rtrn_type_i    <= rows[r].rtype;
        l15_rtrn_tid_i     <= rows[r].tid;
        l15_rtrn_data_i    <= rdata;
        l15_inval_dcache_i <= rows[r].inval_dc;
        l15_inval_icache_i <= rows[r].inval_ic;
        l15_inval_addr_i   <= iaddr;
        resp_ready_i       <= rows[r].rdy;
        inval_ready_i      <= rows[r].ivrdy;
        @(negedge clk_i);
        check_eq("resp_valid_o", resp_valid_o, rows[r].exp_valid);
        check_eq("l15_req_ack_o", l15_req_ack_o, rows[r].exp_ack);
        check_eq("inval_dcache_o", inval_dcache_o, rows[r].inval_dc);
        check_eq("inval_icache_o", inval_icache_o, rows[r].inval_ic);
        check_eq("inval_addr_o", inval_addr_o, iaddr);
        check_eq("resp_error_o", resp_error_o, rows[r].rtype == l15_pkg::RetErr);
        if (rows[r].exp_valid) begin
            check_eq("resp_id_o", resp_id_o, sent_id[rows[r].tid]);
            check_eq("resp_pid_o", resp_pid_o, exp_pid);
            check_eq("resp_data_o", resp_data_o, {exp_hi, exp_lo});
        end
        @(posedge clk_i);
        l15_rtrn_val_i     <= 1'b0;
        l15_inval_dcache_i <= 1'b0;
        l15_inval_icache_i <= 1'b0;
        resp_ready_i       <= 1'b1;
        inval_ready_i      <= 1'b1;
    endtask

    initial begin
        int err_before;
        seed               = 32'h59c8;
        errors             = 0;
        failed             = 0;
        nrows              = 0;
        rst_ni             = 1'b0;
        req_valid_i        = 1'b0;
        req_index_i        = '0;
        req_cmd_i          = '0;
        req_id_i           = '0;
        req_pid_i          = '0;
        req_addr_i         = '0;
        req_size_i         = '0;
        req_cacheable_i    = 1'b0;
        req_wdata_i        = '0;
        req_wbe_i          = '0;
        l15_header_ack_i   = 1'b0;
        l15_ack_i          = 1'b0;
        l15_rtrn_val_i     = 1'b0;
        l15_rtrn_type_i    = '0;
        l15_rtrn_tid_i     = '0;
        l15_rtrn_data_i    = '0;
        l15_inval_icache_i = 1'b0;
        l15_inval_dcache_i = 1'b0;
        l15_inval_addr_i   = '0;
        inval_ready_i      = 1'b1;
        resp_ready_i       = 1'b1;

        // Request rows give index cmd size cacheable wbe hdr ack, then rqtype size tid
        add_request(5'h02, 2'd0, 3'd3, 1'b1, 8'h00, 0, 0, 5'd0, 3'd4, 2'd0, "cached load");
        add_request(5'h04, 2'd1, 3'd3, 1'b1, 8'h0c, 0, 0, 5'd1, 3'd2, 2'd1, "masked store");
        add_request(5'h01, 2'd0, 3'd2, 1'b1, 8'h00, 2, 3, 5'd16, 3'd6, 2'd2, "delayed ifill");
        add_request(5'h01, 2'd0, 3'd2, 1'b0, 8'h00, 0, 1, 5'd16, 3'd3, 2'd3, "uncached ifill");
        add_blocked("free list empty");
        // Return rows give tid type inval_dc inval_ic resp_ready inval_ready, then valid ack
        add_return(2'd1, 4'd4, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, "store ack held");
        add_return(2'd1, 4'd4, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, "store ack");
        add_return(2'd0, 4'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, "load return");
        add_return(2'd2, 4'd12, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, "error return");
        add_request(5'h02, 2'd0, 3'd1, 1'b1, 8'h00, 1, 2, 5'd0, 3'd2, 2'd1, "reused id");
        add_request(5'h10, 2'd1, 3'd2, 1'b0, 8'h0f, 0, 0, 5'd1, 3'd3, 2'd0, "uncached store");
        add_return(2'd3, 4'd3, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, "inval held");
        add_return(2'd3, 4'd3, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, "inval only");
        add_return(2'd3, 4'd3, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, "icache inval");
        add_return(2'd1, 4'd0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, "inval with load held");
        add_request(5'h04, 2'd1, 3'd3, 1'b1, 8'hff, 0, 0, 5'd1, 3'd4, 2'd2, "full store");
        add_blocked("eviction frees no id");

        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;

        for (int r = 0; r < nrows; r++) begin
            err_before = errors;
            case (rows[r].op)
                OpReq:   run_request(r);
                OpBlock: run_blocked(r);
                default: run_return(r);
            endcase
            if (errors != err_before) begin
                failed++;
            end
            $display("Test %0d %s: %s", r, row_name[r], (errors == err_before) ? "ok" : "FAILED");
        end

        $display("Tests run %0d, tests failed %0d, errors %0d", nrows, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- thread_ctrl/free_thid_fifo.sv
// Free thread id list
`timescale 1ns/1ps

module free_thid_fifo (
    input  logic          clk_i,
    input  logic          rst_ni,
    input  logic          push_i,
    input  l15_pkg::tid_t push_tid_i,
    input  logic          pop_i,
    output logic          avail_o,
    output l15_pkg::tid_t tid_o
);

    l15_pkg::tid_t               list_q [l15_pkg::NumTids];
    l15_pkg::tid_t               rd_ptr_q;    // One entry per id, pointers wrap
    l15_pkg::tid_t               wr_ptr_q;
    logic [l15_pkg::TidWidth:0]  count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < l15_pkg::NumTids; i++) begin
                list_q[i] <= l15_pkg::tid_t'(i);   // Every id free
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= (l15_pkg::TidWidth + 1)'(l15_pkg::NumTids);
        end else begin
            if (push_i) begin
                list_q[wr_ptr_q] <= push_tid_i;
                wr_ptr_q         <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + push_i - pop_i;
        end
    end

    assign avail_o = (count_q != '0);
    assign tid_o   = list_q[rd_ptr_q];

    a_no_ovf: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (push_i -> count_q != l15_pkg::NumTids) && (pop_i -> avail_o));

endmodule

//--- thread_ctrl/thread_ctrl.sv
// L1.5 request protocol and id allocation
`timescale 1ns/1ps

module thread_ctrl (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              req_valid_i,
    input  mem_req_pkg::mem_id_t              req_id_i,
    input  mem_req_pkg::pid_t                 req_pid_i,
    input  logic                              l15_header_ack_i,
    input  logic                              l15_ack_i,
    dec_req_if.consumer                       dec,
    thid_if.alloc_side                        thid,
    output logic                              req_ready_o,
    output logic                              l15_val_o,
    output l15_pkg::rqtype_t                  l15_rqtype_o,
    output logic                              l15_nc_o,
    output l15_pkg::size_t                    l15_size_o,
    output l15_pkg::tid_t                     l15_tid_o,
    output logic [mem_req_pkg::AddrWidth-1:0] l15_address_o,
    output logic [l15_pkg::DataWidth-1:0]     l15_data_o,
    output logic [l15_pkg::BeWidth-1:0]       l15_be_o
);

    typedef enum logic [1:0] {IDLE, WAIT_HDR, WAIT_ACK} state_e;

    state_e state_q;
    state_e state_d;
    logic   tid_avail;
    logic   accept;      // Ack seen, request handed over

    free_thid_fifo u_free_thid (
        .clk_i,
        .rst_ni,
        .push_i     (thid.release_en),
        .push_tid_i (thid.release_tid),
        .pop_i      (accept),
        .avail_o    (tid_avail),
        .tid_o      (l15_tid_o)    // Head id goes out with the request
    );

    always_comb begin
        state_d   = state_q;
        l15_val_o = 1'b0;
        accept    = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && tid_avail) begin
                    l15_val_o = 1'b1;
                    if (!l15_header_ack_i) begin
                        state_d = WAIT_HDR;
                    end else if (l15_ack_i) begin
                        accept = 1'b1;         // Zero-cycle handover
                    end else begin
                        state_d = WAIT_ACK;
                    end
                end
            end
            WAIT_HDR: begin
                l15_val_o = 1'b1;
                if (req_valid_i && l15_header_ack_i) begin
                    accept  = l15_ack_i;
                    state_d = l15_ack_i ? IDLE : WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                // Valid drops, fields stay
                if (req_valid_i && l15_ack_i) begin
                    accept  = 1'b1;
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign req_ready_o    = accept;
    assign thid.alloc     = accept;
    assign thid.alloc_tid = l15_tid_o;
    assign thid.alloc_id  = req_id_i;
    assign thid.alloc_pid = req_pid_i;

    assign l15_rqtype_o  = dec.rqtype;
    assign l15_nc_o      = dec.nc;
    assign l15_size_o    = dec.size;
    assign l15_address_o = dec.address;
    assign l15_data_o    = dec.data;
    assign l15_be_o      = dec.be;

    // Cache side holds its request until ready
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q != IDLE |-> req_valid_i);

endmodule

//--- vlog.f
common/l15_pkg.sv
common/mem_req_pkg.sv
common/dec_req_if.sv
common/thid_if.sv
rtl/req_decode.sv
thread_ctrl/free_thid_fifo.sv
thread_ctrl/thread_ctrl.sv
rtl/resp_route.sv
rtl/l15_adapter.sv
sim/tb_l15_adapter.sv
